// ==== list.f ====
+incdir+design
design/posit_pkg.sv
design/leading_zero_counter.sv
design/posit_decoder.sv
design/posit_multiplier.sv
design/quire_accumulator.sv
design/product_counter.sv
design/mac_sequencer.sv
design/quire_to_posit.sv
design/posit_mac_top.sv
tests/posit_mac_tb.sv

// ==== tests/posit_mac_tb.sv ====
`timescale 1ns/1ns
`include "posit_params.svh"

module posit_mac_tb import posit_pkg::*; ();

    localparam int RESET_CYCLES = 8;
    localparam int PIPE_STAGES  = 6;       // last pair driven -> result seen
    localparam int MAX_GAP      = 3;
    localparam int NUM_DOTS     = 37;
    localparam int TIMEOUT      = NUM_DOTS * (`POSIT_DOT_LEN + PIPE_STAGES + MAX_GAP) * 2
                                  + RESET_CYCLES;

    logic   clk_i;
    logic   rstn;
    logic   vld_i;
    posit_t win_i;
    posit_t din_i;
    posit_t acc_o;
    logic   vld_o;

    posit_t      dot_w [`POSIT_DOT_LEN];
    posit_t      dot_d [`POSIT_DOT_LEN];
    posit_t      exp_q [$];                // expected results in order
    string       name_q [$];
    logic [31:0] lcg_state = 32'h7f92_87b9;
    int          cycle = 0;
    int          drive_cycle;
    int          vld_cycle;
    int          results_seen = 0;
    int          checks = 0;
    int          errors = 0;

    posit_mac_top posit_mac_top_i (
        .clk_i (clk_i),
        .rstn  (rstn),
        .vld_i (vld_i),
        .win_i (win_i),
        .din_i (din_i),
        .acc_o (acc_o),
        .vld_o (vld_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT) begin
            $display("timeout: no result after %0d cycles", cycle);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic void decode(input posit_t p, output bit neg, output int scale,
                                   output int mant);
        logic [7:0] a;
        bit         r0;
        int         i;
        int         run;
        int         k;
        int         e;
        int         f;
        neg = p[7];
        a   = p[7] ? -p : p;
        r0  = a[6];
        run = 0;
        i   = 6;
        while (i >= 0 && a[i] == r0) begin
            run++;
            i--;
        end
        k = r0 ? run - 1 : -run;
        i--;                               // skip terminator
        e = 0;
        f = 0;
        repeat (2) begin
            e = 2 * e + ((i >= 0) ? int'(a[i]) : 0);
            i--;
        end
        repeat (3) begin
            f = 2 * f + ((i >= 0) ? int'(a[i]) : 0);
            i--;
        end
        scale = 4 * k + e;
        mant  = 8 + f;                     // 1.fff as integer
    endfunction

    // exact product in units of 2^-48
    function automatic logic signed [127:0] product_term(input posit_t w, input posit_t d);
        bit                  nw;
        bit                  nd;
        int                  sw;
        int                  sd;
        int                  mw;
        int                  md;
        int                  sh;
        logic signed [127:0] t;
        if (w == 8'h00 || w == 8'h80 || d == 8'h00 || d == 8'h80) begin
            return 0;
        end
        decode(w, nw, sw, mw);
        decode(d, nd, sd, md);
        sh = sw + sd - 6 + 48;
        t  = mw * md;
        t  = (sh >= 0) ? (t << sh) : (t >>> -sh);
        return (nw ^ nd) ? -t : t;
    endfunction

    function automatic posit_t encode(input logic signed [127:0] sum);
        logic [127:0] mag;
        logic [191:0] str;                 // ideal posit bit string after the sign
        logic [6:0]   body;
        int           top;
        int           s;
        int           k;
        int           e;
        int           pos;
        if (sum == 0) begin
            return 8'h00;
        end
        mag = (sum < 0) ? -sum : sum;
        top = 0;
        for (int i = 0; i < 128; i++) begin
            if (mag[i]) begin
                top = i;
            end
        end
        s = top - 48;
        if (s > 24) begin
            return (sum < 0) ? 8'h81 : 8'h7f;
        end
        if (s < -24) begin
            return 8'h00;
        end
        k   = (s >= 0) ? s / 4 : -((3 - s) / 4);   // floor
        e   = s - 4 * k;
        str = '0;
        pos = 191;
        if (k >= 0) begin
            repeat (k + 1) begin
                str[pos] = 1'b1;
                pos--;
            end
            pos--;                         // zero terminator
        end else begin
            pos = pos + k;
            str[pos] = 1'b1;
            pos--;
        end
        str[pos]     = e[1];
        str[pos - 1] = e[0];
        pos          = pos - 2;
        for (int i = top - 1; i >= 0; i--) begin
            str[pos] = mag[i];
            pos--;
        end
        body = str[191:185];
        if (str[184] && (body[0] || (|str[183:0]))) begin
            body = body + 1'b1;            // nearest, ties to even
        end
        return (sum < 0) ? -{1'b0, body} : {1'b0, body};
    endfunction

    function automatic posit_t dot_model();
        logic signed [127:0] sum;
        sum = 0;
        for (int i = 0; i < `POSIT_DOT_LEN; i++) begin
            sum = sum + product_term(dot_w[i], dot_d[i]);
        end
        return encode(sum);
    endfunction

    // --------------------
    // checks and driving
    // --------------------
    task automatic check_posit(input string name, input posit_t expected, input posit_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("error: %s expected %02h actual %02h", name, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("error: %s expected cycle %0d actual cycle %0d", name, expected, actual);
        end
    endtask

    always @(negedge clk_i) begin
        if (rstn && vld_o) begin
            vld_cycle = cycle;
            results_seen++;
            if (exp_q.size() == 0) begin
                errors++;
                $display("output valid seen with no dot product pending");
            end else begin
                check_posit(name_q.pop_front(), exp_q.pop_front(), acc_o);
            end
        end
    end

    task automatic feed_pair(input posit_t w, input posit_t d);
        vld_i       = 1'b1;
        win_i       = w;
        din_i       = d;
        drive_cycle = cycle;
        @(negedge clk_i);
        vld_i = 1'b0;
    endtask

    task automatic send_dot(input string name, input posit_t expected, input int max_gap);
        int gap;
        name_q.push_back(name);
        exp_q.push_back(expected);
        for (int i = 0; i < `POSIT_DOT_LEN; i++) begin
            feed_pair(dot_w[i], dot_d[i]);
            gap = (max_gap > 0) ? int'(next_random() % (max_gap + 1)) : 0;
            repeat (gap) @(negedge clk_i);
        end
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    task automatic fill_dot(input bit random, input posit_t w, input posit_t d);
        for (int i = 0; i < `POSIT_DOT_LEN; i++) begin
            dot_w[i] = random ? posit_t'(next_random() >> 16) : w;
            dot_d[i] = random ? posit_t'(next_random() >> 16) : d;
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_exact_sums();
        fill_dot(0, 8'h40, 8'h40);
        send_dot("nine ones", 8'h59, 0);   // 9.0
        fill_dot(0, 8'h00, 8'h00);
        dot_w[4] = 8'h44;                  // 1.5
        dot_d[4] = 8'h48;                  // 2.0
        send_dot("one product", 8'h4c, 0); // 3.0
        wait_results();
    endtask

    task automatic test_zero_nar();
        repeat (2) begin
            fill_dot(1, 8'h00, 8'h00);
            dot_w[2] = 8'h00;
            dot_d[5] = 8'h80;
            dot_w[7] = 8'h80;
            dot_d[8] = 8'h00;
            send_dot("zero and nar", dot_model(), 0);
        end
        wait_results();
    endtask

    task automatic test_cancel_saturate();
        fill_dot(1, 8'h00, 8'h00);
        for (int i = 0; i < 4; i++) begin
            dot_w[2 * i + 1] = -dot_w[2 * i];
            dot_d[2 * i + 1] = dot_d[2 * i];
        end
        dot_w[8] = 8'h00;
        send_dot("cancel", 8'h00, 0);
        fill_dot(0, 8'h7f, 8'h7f);
        send_dot("overflow positive", 8'h7f, 0);
        fill_dot(0, 8'h81, 8'h7f);
        send_dot("overflow negative", 8'h81, 0);
        fill_dot(0, 8'h01, 8'h01);
        send_dot("underflow", 8'h00, 0);
        wait_results();
    endtask

    task automatic test_latency();
        int seen;
        fill_dot(1, 8'h00, 8'h00);
        name_q.push_back("latency value");
        exp_q.push_back(dot_model());
        seen = results_seen;
        for (int i = 0; i < `POSIT_DOT_LEN - 1; i++) begin
            feed_pair(dot_w[i], dot_d[i]);
        end
        repeat (12) @(negedge clk_i);
        if (results_seen != seen) begin
            errors++;
            $display("output valid appeared after only eight pairs");
        end
        feed_pair(dot_w[`POSIT_DOT_LEN-1], dot_d[`POSIT_DOT_LEN-1]);
        while (results_seen == seen) begin
            @(negedge clk_i);
        end
        check_latency("latency", drive_cycle + PIPE_STAGES, vld_cycle);
    endtask

    task automatic test_streams();
        repeat (3) begin
            fill_dot(1, 8'h00, 8'h00);
            send_dot("back to back", dot_model(), 0);
        end
        repeat (3) begin
            fill_dot(1, 8'h00, 8'h00);
            send_dot("random gaps", dot_model(), MAX_GAP);
        end
        wait_results();
    endtask

    task automatic test_random();
        repeat (20) begin
            fill_dot(1, 8'h00, 8'h00);
            send_dot("random", dot_model(), 0);
        end
        fill_dot(0, 8'h00, 8'h00);
        dot_w[0] = 8'h40;                  // 1.0 + 2^-4, tie rounds down
        dot_d[0] = 8'h40;
        dot_w[1] = 8'h20;
        dot_d[1] = 8'h40;
        send_dot("tie to even down", 8'h40, 0);
        dot_w[0] = 8'h41;                  // 1.125 + 2^-4, tie rounds up
        send_dot("tie to even up", 8'h42, 0);
        wait_results();
    endtask

    initial begin
        rstn  = 1'b0;
        vld_i = 1'b0;
        win_i = '0;
        din_i = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rstn = 1'b1;
        @(negedge clk_i);
        test_exact_sums();
        test_zero_nar();
        test_cancel_saturate();
        test_latency();
        test_streams();
        test_random();
        repeat (PIPE_STAGES + 2) @(negedge clk_i);   // catch stray valids
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== design/posit_mac_top.sv ====
`timescale 1ns/1ns

module posit_mac_top import posit_pkg::*; (
    input  logic   clk_i,
    input  logic   rstn,
    input  logic   vld_i,
    input  posit_t win_i,
    input  posit_t din_i,
    output posit_t acc_o,
    output logic   vld_o
);

    // decoded weight and datum
    logic        dec_vld;
    logic        w_sign;
    scale_t      w_scale;
    frac_t       w_frac;
    logic        w_zero;
    logic        w_nar;
    logic        d_sign;
    scale_t      d_scale;
    frac_t       d_frac;
    logic        d_zero;
    logic        d_nar;

    // product and control
    logic        prod_vld;
    logic        prod_sign;
    prod_scale_t prod_scale;
    prod_frac_t  prod_frac;
    logic        count_en;
    logic        last;
    logic        handoff;
    quire_t      quire;
    logic        sum_vld;

    posit_decoder u_dec_w (
        .clk_i   (clk_i),
        .rstn    (rstn),
        .vld_i   (vld_i),
        .posit_i (win_i),
        .vld_o   (dec_vld),
        .sign_o  (w_sign),
        .scale_o (w_scale),
        .frac_o  (w_frac),
        .zero_o  (w_zero),
        .nar_o   (w_nar)
    );

    posit_decoder u_dec_d (
        .clk_i   (clk_i),
        .rstn    (rstn),
        .vld_i   (vld_i),
        .posit_i (din_i),
        .vld_o   (),
        .sign_o  (d_sign),
        .scale_o (d_scale),
        .frac_o  (d_frac),
        .zero_o  (d_zero),
        .nar_o   (d_nar)
    );

    posit_multiplier u_mul (
        .clk_i     (clk_i),
        .rstn      (rstn),
        .vld_i     (dec_vld),
        .a_sign_i  (w_sign),
        .a_scale_i (w_scale),
        .a_frac_i  (w_frac),
        .a_zero_i  (w_zero),
        .a_nar_i   (w_nar),
        .b_sign_i  (d_sign),
        .b_scale_i (d_scale),
        .b_frac_i  (d_frac),
        .b_zero_i  (d_zero),
        .b_nar_i   (d_nar),
        .vld_o     (prod_vld),
        .sign_o    (prod_sign),
        .scale_o   (prod_scale),
        .frac_o    (prod_frac)
    );

    quire_accumulator u_acc (
        .clk_i      (clk_i),
        .rstn       (rstn),
        .prod_vld_i (prod_vld),
        .sign_i     (prod_sign),
        .scale_i    (prod_scale),
        .frac_i     (prod_frac),
        .handoff_i  (handoff),
        .quire_o    (quire),
        .sum_vld_o  (sum_vld)
    );

    product_counter u_cnt (
        .clk_i      (clk_i),
        .rstn       (rstn),
        .count_en_i (count_en),
        .last_o     (last)
    );

    mac_sequencer u_seq (
        .clk_i      (clk_i),
        .rstn       (rstn),
        .prod_vld_i (prod_vld),
        .last_i     (last),
        .count_en_o (count_en),
        .handoff_o  (handoff)
    );

    quire_to_posit u_cvt (
        .clk_i     (clk_i),
        .rstn      (rstn),
        .sum_vld_i (sum_vld),
        .quire_i   (quire),
        .acc_o     (acc_o),
        .vld_o     (vld_o)
    );

endmodule

// ==== design/quire_to_posit.sv ====
`timescale 1ns/1ns
`include "posit_params.svh"

module quire_to_posit import posit_pkg::*; (
    input  logic   clk_i,
    input  logic   rstn,
    input  logic   sum_vld_i,
    input  quire_t quire_i,
    output posit_t acc_o,
    output logic   vld_o
);

    localparam int     QW        = `QUIRE_WIDTH;
    localparam int     LZW       = $clog2(QW + 1);
    localparam int     BW        = `POSIT_WIDTH - 1;
    localparam int     ES        = `POSIT_ES;
    localparam int     FK        = `POSIT_FRAC_BITS + 1;          // fraction plus one more
    localparam int     MAX_SH    = `POSIT_WIDTH - 2;              // longest regime shift
    localparam int     ENC_W     = 2 + ES + FK + MAX_SH;
    localparam int     KW        = $bits(prod_scale_t) - ES;
    localparam int     MAX_SCALE = (1 << ES) * (`POSIT_WIDTH - 2);   // maxpos = 2^24
    localparam posit_t MAXPOS    = {1'b0, {BW{1'b1}}};
    localparam posit_t MAXNEG    = {1'b1, {(BW-1){1'b0}}, 1'b1};

    // stage A signals
    logic [QW-1:0]   mag;
    logic [LZW-1:0]  lz;
    logic            lz_zero;
    logic [QW-1:0]   norm;
    prod_scale_t     scale_d;
    logic            a_vld;
    logic            a_sign;
    logic            a_ovf;
    logic            a_udf;
    logic            a_sticky;
    prod_scale_t     a_scale;
    logic [FK-1:0]   a_frac;

    // stage B signals
    logic signed [KW-1:0]    k;
    logic [KW-1:0]           shamt;
    logic signed [ENC_W-1:0] seed;
    logic [ENC_W-1:0]        pattern;
    logic [BW-1:0]           body;
    logic                    guard;
    logic                    sticky;
    logic                    round_up;
    logic                    b_vld;
    logic                    b_sign;
    logic                    b_ovf;
    logic                    b_udf;
    logic [BW-1:0]           b_body;

    // --------------------
    // stage A: normalize
    // --------------------
    always_comb begin
        mag     = quire_i[QW-1] ? -quire_i : quire_i;
        norm    = mag << lz;                                  // leading one at top
        scale_d = prod_scale_t'(`QUIRE_CARRY_BITS + `QUIRE_INT_BITS) - prod_scale_t'(lz);
    end

    leading_zero_counter #(
        .WIDTH (QW)
    ) u_lzc (
        .data_i  (mag),
        .count_o (lz),
        .zero_o  (lz_zero)
    );

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            a_vld <= 1'b0;
        end else begin
            a_vld <= sum_vld_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (sum_vld_i) begin
            a_sign   <= quire_i[QW-1];
            a_scale  <= scale_d;
            a_frac   <= norm[QW-2 -: FK];
            a_sticky <= |norm[QW-2-FK:0];
            a_ovf    <= (scale_d > MAX_SCALE);
            a_udf    <= lz_zero | (scale_d < -MAX_SCALE);     // below minpos, or zero
        end
    end

    // --------------------
    // stage B: encode, round
    // --------------------
    always_comb begin
        k        = a_scale[$bits(prod_scale_t)-1:ES];         // floor(scale / 4)
        shamt    = k[KW-1] ? ~k : k;                          // -k-1 or k
        seed     = {~k[KW-1], k[KW-1], a_scale[ES-1:0], a_frac, {MAX_SH{1'b0}}};
        pattern  = seed >>> shamt;                            // grow the regime run
        body     = pattern[ENC_W-1 -: BW];
        guard    = pattern[ENC_W-1-BW];
        sticky   = (|pattern[ENC_W-2-BW:0]) | a_sticky;
        round_up = guard & (body[0] | sticky) & ~a_ovf & ~a_udf;   // nearest even
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            b_vld <= 1'b0;
        end else begin
            b_vld <= a_vld;
        end
    end

    always_ff @(posedge clk_i) begin
        if (a_vld) begin
            b_sign <= a_sign;
            b_ovf  <= a_ovf;
            b_udf  <= a_udf;
            b_body <= body + round_up;
        end
    end

    // --------------------
    // stage C: sign, saturate
    // --------------------
    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_o <= 1'b0;
            acc_o <= '0;
        end else begin
            vld_o <= b_vld;
            if (b_vld) begin
                if (b_udf) begin
                    acc_o <= '0;
                end else if (b_ovf) begin
                    acc_o <= b_sign ? MAXNEG : MAXPOS;
                end else if (b_sign) begin
                    acc_o <= -{1'b0, b_body};
                end else begin
                    acc_o <= {1'b0, b_body};
                end
            end
        end
    end

endmodule

// ==== design/mac_sequencer.sv ====
`timescale 1ns/1ns

module mac_sequencer (
    input  logic clk_i,
    input  logic rstn,
    input  logic prod_vld_i,
    input  logic last_i,
    output logic count_en_o,
    output logic handoff_o
);

    typedef enum logic {
        IDLE,                                        // quire empty
        ACCUM                                        // dot product under way
    } state_t;

    state_t state_q;
    state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (prod_vld_i) begin
                    state_d = ACCUM;
                end
            end
            ACCUM: begin
                if (prod_vld_i && last_i) begin
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign count_en_o = prod_vld_i;
    assign handoff_o  = prod_vld_i & last_i & (state_q == ACCUM);

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== design/product_counter.sv ====
`timescale 1ns/1ns
`include "posit_params.svh"

module product_counter import posit_pkg::*; (
    input  logic clk_i,
    input  logic rstn,
    input  logic count_en_i,
    output logic last_o
);

    count_t count_q;

    assign last_o = (count_q == count_t'(`POSIT_DOT_LEN - 1));

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            count_q <= '0;
        end else if (count_en_i) begin
            if (last_o) begin
                count_q <= '0;                       // wrap
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

endmodule

// ==== design/quire_accumulator.sv ====
`timescale 1ns/1ns
`include "posit_params.svh"

module quire_accumulator import posit_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn,
    input  logic        prod_vld_i,
    input  logic        sign_i,
    input  prod_scale_t scale_i,
    input  prod_frac_t  frac_i,
    input  logic        handoff_i,
    output quire_t      quire_o,
    output logic        sum_vld_o
);

    localparam int FP    = 2 * `POSIT_FRAC_BITS;     // product binary point
    localparam int EXT_W = `QUIRE_WIDTH + FP;

    logic [$bits(prod_scale_t)-1:0] shamt;
    logic [EXT_W-1:0]               ext;
    quire_t                         aligned;
    quire_t                         addend;
    quire_t                         sum_q;
    quire_t                         sum_d;

    always_comb begin
        shamt   = $unsigned(scale_i + prod_scale_t'(`QUIRE_FRAC_BITS));   // 0 .. 96
        ext     = EXT_W'(frac_i) << shamt;
        aligned = ext[EXT_W-1:FP];                   // low bits are always zero
        addend  = sign_i ? -aligned : aligned;
        sum_d   = sum_q + addend;
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            sum_q     <= '0;
            sum_vld_o <= 1'b0;
        end else begin
            sum_vld_o <= handoff_i;
            if (handoff_i) begin
                sum_q <= '0;                         // next dot product starts clean
            end else if (prod_vld_i) begin
                sum_q <= sum_d;
            end
        end
    end

    // finished sum includes the last product
    always_ff @(posedge clk_i) begin
        if (handoff_i) begin
            quire_o <= sum_d;
        end
    end

endmodule

// ==== design/posit_multiplier.sv ====
`timescale 1ns/1ns

module posit_multiplier import posit_pkg::*; (
    input  logic        clk_i,
    input  logic        rstn,
    input  logic        vld_i,
    input  logic        a_sign_i,
    input  scale_t      a_scale_i,
    input  frac_t       a_frac_i,
    input  logic        a_zero_i,
    input  logic        a_nar_i,
    input  logic        b_sign_i,
    input  scale_t      b_scale_i,
    input  frac_t       b_frac_i,
    input  logic        b_zero_i,
    input  logic        b_nar_i,
    output logic        vld_o,
    output logic        sign_o,
    output prod_scale_t scale_o,
    output prod_frac_t  frac_o
);

    logic skip;

    assign skip = a_zero_i | a_nar_i | b_zero_i | b_nar_i;   // product adds nothing

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_o <= 1'b0;
        end else begin
            vld_o <= vld_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            sign_o  <= a_sign_i ^ b_sign_i;
            scale_o <= prod_scale_t'(a_scale_i) + prod_scale_t'(b_scale_i);
            frac_o  <= skip ? '0 : a_frac_i * b_frac_i;       // exact 4x4
        end
    end

endmodule

// ==== design/posit_decoder.sv ====
`timescale 1ns/1ns
`include "posit_params.svh"

module posit_decoder import posit_pkg::*; (
    input  logic   clk_i,
    input  logic   rstn,
    input  logic   vld_i,
    input  posit_t posit_i,
    output logic   vld_o,
    output logic   sign_o,
    output scale_t scale_o,
    output frac_t  frac_o,
    output logic   zero_o,
    output logic   nar_o
);

    localparam int BW = `POSIT_WIDTH - 1;         // body below the sign
    localparam int RW = $clog2(BW + 1);
    localparam int ES = `POSIT_ES;
    localparam int KW = BW - ES;                  // regime value width
    localparam int FB = `POSIT_FRAC_BITS;

    posit_t               abs_val;
    logic [BW-1:0]        body;
    logic [BW-1:0]        body_inv;
    logic [RW-1:0]        run_len;
    logic signed [KW-1:0] regime;
    logic [BW-1:0]        rem;
    scale_t               scale_d;
    frac_t                frac_d;

    always_comb begin
        abs_val  = posit_i[BW] ? -posit_i : posit_i;
        body     = abs_val[BW-1:0];
        body_inv = body[BW-1] ? ~body : body;     // regime run -> leading zeros
    end

    leading_zero_counter #(
        .WIDTH (BW)
    ) u_lzc (
        .data_i  (body_inv),
        .count_o (run_len),
        .zero_o  ()
    );

    always_comb begin
        if (body[BW-1]) begin
            regime = $signed(KW'(run_len)) - 1;   // ones: k = m - 1
        end else begin
            regime = -$signed(KW'(run_len));      // zeros: k = -m
        end
        // drop regime run and terminator, cut bits read as zero
        rem     = body << ({1'b0, run_len} + 1'b1);
        scale_d = {regime, rem[BW-1 -: ES]};
        frac_d  = {1'b1, rem[BW-1-ES -: FB]};
    end

    always_ff @(posedge clk_i or negedge rstn) begin
        if (!rstn) begin
            vld_o <= 1'b0;
        end else begin
            vld_o <= vld_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (vld_i) begin
            sign_o  <= posit_i[BW];
            scale_o <= scale_d;
            frac_o  <= frac_d;
            zero_o  <= (posit_i == '0);
            nar_o   <= (posit_i == {1'b1, {BW{1'b0}}});   // 1000_0000
        end
    end

endmodule

// ==== design/leading_zero_counter.sv ====
`timescale 1ns/1ns

module leading_zero_counter #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]           data_i,
    output logic [$clog2(WIDTH+1)-1:0] count_o,
    output logic                       zero_o
);

    localparam int CW = $clog2(WIDTH + 1);

    // scan upward so the highest set bit wins
    always_comb begin
        count_o = CW'(WIDTH);                       // nothing set
        for (int i = 0; i < WIDTH; i++) begin
            if (data_i[i]) begin
                count_o = CW'(WIDTH - 1 - i);
            end
        end
    end

    assign zero_o = ~|data_i;

endmodule

// ==== design/posit_pkg.sv ====
`include "posit_params.svh"

package posit_pkg;

    // raw posit bit pattern
    typedef logic [`POSIT_WIDTH-1:0] posit_t;

    // regime * 2^es + exponent, one operand
    typedef logic signed [`POSIT_WIDTH-2:0] scale_t;

    // sum of two operand scales
    typedef logic signed [`POSIT_WIDTH-1:0] prod_scale_t;

    typedef logic [`POSIT_FRAC_BITS:0] frac_t;             // 1.fff
    typedef logic [2*`POSIT_FRAC_BITS+1:0] prod_frac_t;    // 01.xxxxxx or 1x.xxxxxx

    // two's complement fixed point, binary point at QUIRE_FRAC_BITS
    typedef logic signed [`QUIRE_WIDTH-1:0] quire_t;

    typedef logic [$clog2(`POSIT_DOT_LEN+1)-1:0] count_t;

endpackage

// ==== design/posit_params.svh ====
`ifndef POSIT_PARAMS_SVH
`define POSIT_PARAMS_SVH

// --------------------
// posit format
// --------------------
`define POSIT_WIDTH      8
`define POSIT_ES         2
`define POSIT_DOT_LEN    9                                // products per dot product
`define POSIT_FRAC_BITS  (`POSIT_WIDTH - 3 - `POSIT_ES)   // stored fraction bits

// --------------------
// quire geometry
// --------------------
`define QUIRE_FRAC_BITS  48   // down to minpos * minpos
`define QUIRE_INT_BITS   49   // up to maxpos * maxpos
`define QUIRE_CARRY_BITS 4    // headroom for a full dot product
`define QUIRE_WIDTH      (1 + `QUIRE_CARRY_BITS + `QUIRE_INT_BITS + `QUIRE_FRAC_BITS)

`endif
